//--- rtl/riscv_isa_pkg.sv
/*
 * RISC-V ISA encodings
 * Major opcodes, funct3/funct7 codes and instruction field positions
 * for the RV32I integer ALU instructions
 */
package riscv_isa_pkg;

  // Major opcodes, ALU subset only
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011
  } opcode_e;

  // funct3 codes shared by R-type and I-type
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 codes, ALT selects SUB and SRA/SRAI
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // Field LSB positions within the instruction word
  localparam int unsigned OPC_LSB = 0;
  localparam int unsigned RD_LSB  = 7;
  localparam int unsigned F3_LSB  = 12;
  localparam int unsigned RS1_LSB = 15;
  localparam int unsigned RS2_LSB = 20;
  localparam int unsigned F7_LSB  = 25;
  localparam int unsigned IMM_LSB = 20;

  // Field widths
  localparam int unsigned REG_AW = 5;
  localparam int unsigned IMM_W  = 12;

endpackage

//--- rtl/exec_pkg.sv
/*
 * Execute subsystem types
 * ALU operation and operand-B source encodings
 */
package exec_pkg;

  // ALU operations, one per RV32I ALU function
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // Operand B source
  typedef enum logic {
    OPB_REG,
    OPB_IMM
  } op_b_sel_e;

endpackage

//--- rtl/reg_file.sv
/*
 * Register file
 * Flip-flop storage for x1..x31 (x1..x15 with RV32E), x0 reads zero,
 * two combinational read ports and one synchronous write port
 */
`timescale 1ns/1ps

module reg_file #(
  parameter bit RV32E = 0
) (
  input  logic        clk_int,
  input  logic        rst_ni,
  input  logic [4:0]  raddr_a_i,
  input  logic [4:0]  raddr_b_i,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i,
  input  logic        we_i,
  output logic [31:0] rdata_a_o,
  output logic [31:0] rdata_b_o
);

  localparam int unsigned ADDR_WIDTH = RV32E ? 4 : 5;
  localparam int unsigned NUM_WORDS  = 2 ** ADDR_WIDTH;

  // Storage has no entry 0
  logic [31:0] rf_q [1:NUM_WORDS-1];
  // Read view, entry 0 tied to zero
  logic [31:0] rf_rd [NUM_WORDS];

  // Upper address bit dropped under RV32E
  logic [ADDR_WIDTH-1:0] raddr_a_int;
  logic [ADDR_WIDTH-1:0] raddr_b_int;
  logic [ADDR_WIDTH-1:0] waddr_int;

  assign raddr_a_int = raddr_a_i[ADDR_WIDTH-1:0];
  assign raddr_b_int = raddr_b_i[ADDR_WIDTH-1:0];
  assign waddr_int   = waddr_i[ADDR_WIDTH-1:0];

  assign rf_rd[0] = '0;
  for (genvar i = 1; i < NUM_WORDS; i++) begin : g_rd_view
    assign rf_rd[i] = rf_q[i];
  end

  assign rdata_a_o = rf_rd[raddr_a_int];
  assign rdata_b_o = rf_rd[raddr_b_int];

  // One-hot write, all registers cleared on reset
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NUM_WORDS; i++) begin
        rf_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < NUM_WORDS; i++) begin
        if (we_i && (waddr_int == ADDR_WIDTH'(i))) begin
          rf_q[i] <= wdata_i;
        end
      end
    end
  end

endmodule

//--- rtl/alu.sv
/*
 * Integer ALU
 * Combinational add/sub, compares, shifts and bitwise logic
 */
`timescale 1ns/1ps

module alu
  import exec_pkg::*;
(
  input  logic [31:0] op_a_i,
  input  logic [31:0] op_b_i,
  input  alu_op_e     alu_op_i,
  output logic [31:0] result_o
);

  logic [4:0]  shamt;
  logic        lt_signed;
  logic        lt_unsigned;
  logic [31:0] sra_res;

  // Shift amount from low bits of B only
  assign shamt = op_b_i[4:0];

  assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
  assign lt_unsigned = op_a_i < op_b_i;

  // Arithmetic shift keeps the sign bit
  assign sra_res = 32'($signed(op_a_i) >>> shamt);

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  result_o = op_a_i + op_b_i;
      ALU_SUB:  result_o = op_a_i - op_b_i;
      ALU_SLL:  result_o = op_a_i << shamt;
      ALU_SLT:  result_o = {31'b0, lt_signed};
      ALU_SLTU: result_o = {31'b0, lt_unsigned};
      ALU_XOR:  result_o = op_a_i ^ op_b_i;
      ALU_SRL:  result_o = op_a_i >> shamt;
      ALU_SRA:  result_o = sra_res;
      ALU_OR:   result_o = op_a_i | op_b_i;
      ALU_AND:  result_o = op_a_i & op_b_i;
      default:  result_o = '0;
    endcase
  end

endmodule

//--- rtl/operand_select.sv
/*
 * Operand selector
 * Bypass from EX, immediate sign extension, operand B choice
 * and the EX-stage operand registers
 */
`timescale 1ns/1ps

module operand_select
  import riscv_isa_pkg::*;
  import exec_pkg::*;
(
  input  logic              clk_int,
  input  logic              rst_ni,
  input  logic [31:0]       rdata_a_i,
  input  logic [31:0]       rdata_b_i,
  input  logic [4:0]        raddr_a_i,
  input  logic [4:0]        raddr_b_i,
  input  logic [IMM_W-1:0]  imm_i,
  input  op_b_sel_e         op_b_sel_i,
  input  logic              ex_we_i,
  input  logic [4:0]        ex_rd_i,
  input  logic [31:0]       alu_result_i,
  output logic [31:0]       ex_op_a_o,
  output logic [31:0]       ex_op_b_o
);

  logic        fwd_a;
  logic        fwd_b;
  logic [31:0] reg_a;
  logic [31:0] reg_b;
  logic [31:0] imm_ext;
  logic [31:0] op_a_d;
  logic [31:0] op_b_d;

  // EX writes the register being read, take the ALU value
  // ex_we_i is never set for rd 0, so x0 is not forwarded
  assign fwd_a = ex_we_i && (ex_rd_i == raddr_a_i);
  assign fwd_b = ex_we_i && (ex_rd_i == raddr_b_i);

  assign reg_a = fwd_a ? alu_result_i : rdata_a_i;
  assign reg_b = fwd_b ? alu_result_i : rdata_b_i;

  // Sign-extend the I-type immediate
  assign imm_ext = {{(32 - IMM_W){imm_i[IMM_W-1]}}, imm_i};

  assign op_a_d = reg_a;
  assign op_b_d = (op_b_sel_i == OPB_IMM) ? imm_ext : reg_b;

  // Operands for the EX stage
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_op_a_o <= '0;
      ex_op_b_o <= '0;
    end else begin
      ex_op_a_o <= op_a_d;
      ex_op_b_o <= op_b_d;
    end
  end

endmodule

//--- rtl/exec_controller.sv
/*
 * Execute controller
 * Decodes RV32I ALU instructions, flags illegal encodings and runs
 * the decode/execute pipeline control and registered result outputs
 */
`timescale 1ns/1ps

module exec_controller
  import riscv_isa_pkg::*;
  import exec_pkg::*;
#(
  parameter bit RV32E = 0
) (
  input  logic        clk_int,
  input  logic        rst_ni,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  input  logic [31:0] alu_result_i,
  output logic [4:0]  raddr_a_o,
  output logic [4:0]  raddr_b_o,
  output logic [11:0] imm_o,
  output op_b_sel_e   op_b_sel_o,
  output logic        ex_we_o,
  output logic [4:0]  ex_rd_o,
  output alu_op_e     ex_alu_op_o,
  output logic        result_valid_o,
  output logic [4:0]  result_rd_o,
  output logic [31:0] result_o,
  output logic        illegal_o
);

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;

  logic    is_r;
  logic    is_i;
  logic    bad_f7;
  logic    bad_reg;
  logic    legal;
  alu_op_e alu_op_d;

  // EX-stage state
  logic ex_valid_q;
  logic ex_illegal_q;

  assign opcode = instr_i[OPC_LSB +: 7];
  assign funct3 = instr_i[F3_LSB +: 3];
  assign funct7 = instr_i[F7_LSB +: 7];
  assign rd     = instr_i[RD_LSB +: REG_AW];
  assign rs1    = instr_i[RS1_LSB +: REG_AW];
  assign rs2    = instr_i[RS2_LSB +: REG_AW];

  assign is_r = (opcode == OPC_OP);
  assign is_i = (opcode == OPC_OP_IMM);

  // Read ports and immediate go straight out
  assign raddr_a_o  = rs1;
  assign raddr_b_o  = rs2;
  assign imm_o      = instr_i[IMM_LSB +: IMM_W];
  assign op_b_sel_o = is_i ? OPB_IMM : OPB_REG;

  // funct3/funct7 to ALU operation
  always_comb begin
    case (funct3)
      F3_ADD_SUB: alu_op_d = (is_r && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_op_d = ALU_SLL;
      F3_SLT:     alu_op_d = ALU_SLT;
      F3_SLTU:    alu_op_d = ALU_SLTU;
      F3_XOR:     alu_op_d = ALU_XOR;
      F3_SR:      alu_op_d = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_op_d = ALU_OR;
      F3_AND:     alu_op_d = ALU_AND;
      default:    alu_op_d = ALU_ADD;
    endcase
  end

  // funct7 checks
  always_comb begin
    bad_f7 = 1'b0;
    if (is_r) begin
      // ALT only for SUB and SRA
      bad_f7 = !((funct7 == F7_BASE) ||
                 (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SR)));
    end else if (is_i && funct3 == F3_SLL) begin
      bad_f7 = (funct7 != F7_BASE);
    end else if (is_i && funct3 == F3_SR) begin
      bad_f7 = (funct7 != F7_BASE) && (funct7 != F7_ALT);
    end
  end

  // RV32E has x0..x15 only, rs2 field is immediate for I-type
  assign bad_reg = RV32E && (rd[4] || rs1[4] || (is_r && rs2[4]));

  assign legal = (is_r || is_i) && !bad_f7 && !bad_reg;

  // D to EX
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_valid_q   <= 1'b0;
      ex_illegal_q <= 1'b0;
      ex_we_o      <= 1'b0;
      ex_rd_o      <= '0;
      ex_alu_op_o  <= ALU_ADD;
    end else begin
      ex_valid_q   <= instr_valid_i;
      ex_illegal_q <= !legal;
      // No write for x0 or illegal encodings
      ex_we_o      <= instr_valid_i && legal && (rd != '0);
      ex_rd_o      <= rd;
      ex_alu_op_o  <= alu_op_d;
    end
  end

  // EX to result outputs, one-cycle pulses
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      result_valid_o <= 1'b0;
      illegal_o      <= 1'b0;
      result_rd_o    <= '0;
      result_o       <= '0;
    end else begin
      result_valid_o <= ex_valid_q && !ex_illegal_q;
      illegal_o      <= ex_valid_q && ex_illegal_q;
      result_rd_o    <= ex_rd_o;
      result_o       <= alu_result_i;
    end
  end

endmodule

//--- rtl/exec_unit_top.sv
/*
 * Execute subsystem top
 * Controller, register file, operand selector and ALU as a
 * two-stage decode/execute pipeline with write-back
 */
`timescale 1ns/1ps

module exec_unit_top
  import exec_pkg::*;
#(
  parameter bit RV32E = 0
) (
  input  logic        clk_int,
  input  logic        rst_ni,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  output logic        result_valid_o,
  output logic [4:0]  result_rd_o,
  output logic [31:0] result_o,
  output logic        illegal_o
);

  // Decode stage
  logic [4:0]  raddr_a;
  logic [4:0]  raddr_b;
  logic [31:0] rdata_a;
  logic [31:0] rdata_b;
  logic [11:0] imm;
  op_b_sel_e   op_b_sel;

  // Execute stage
  logic        ex_we;
  logic [4:0]  ex_rd;
  alu_op_e     ex_alu_op;
  logic [31:0] ex_op_a;
  logic [31:0] ex_op_b;
  logic [31:0] alu_result;

  exec_controller #(
    .RV32E (RV32E)
  ) u_ctrl (
    .clk_int        (clk_int),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .alu_result_i   (alu_result),
    .raddr_a_o      (raddr_a),
    .raddr_b_o      (raddr_b),
    .imm_o          (imm),
    .op_b_sel_o     (op_b_sel),
    .ex_we_o        (ex_we),
    .ex_rd_o        (ex_rd),
    .ex_alu_op_o    (ex_alu_op),
    .result_valid_o (result_valid_o),
    .result_rd_o    (result_rd_o),
    .result_o       (result_o),
    .illegal_o      (illegal_o)
  );

  // Write-back from EX at the closing edge
  reg_file #(
    .RV32E (RV32E)
  ) u_rf (
    .clk_int   (clk_int),
    .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .waddr_i   (ex_rd),
    .wdata_i   (alu_result),
    .we_i      (ex_we),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  operand_select u_opsel (
    .clk_int      (clk_int),
    .rst_ni       (rst_ni),
    .rdata_a_i    (rdata_a),
    .rdata_b_i    (rdata_b),
    .raddr_a_i    (raddr_a),
    .raddr_b_i    (raddr_b),
    .imm_i        (imm),
    .op_b_sel_i   (op_b_sel),
    .ex_we_i      (ex_we),
    .ex_rd_i      (ex_rd),
    .alu_result_i (alu_result),
    .ex_op_a_o    (ex_op_a),
    .ex_op_b_o    (ex_op_b)
  );

  alu u_alu (
    .op_a_i   (ex_op_a),
    .op_b_i   (ex_op_b),
    .alu_op_i (ex_alu_op),
    .result_o (alu_result)
  );

endmodule

//--- tb/exec_tests.svh
/*
 * Directed tests for the execute subsystem
 * Instruction assembly, model update and the test tasks
 */

function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OPC_R};
endfunction

function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
  return {imm, rs1, f3, rd, OPC_I};
endfunction

// Any of x1..x31
function automatic logic [4:0] rand_reg();
  logic [4:0] r;
  r = 5'(rand_bits(5));
  return (r == 5'd0) ? 5'd1 : r;
endfunction

// Strobe one instruction, predict its result two cycles on
task automatic issue_instr(input logic [31:0] instr);
  logic [6:0]  opc;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [4:0]  rd;
  logic        is_r;
  logic        is_i;
  logic        legal;
  logic [31:0] b;
  logic [31:0] res;
  opc   = instr[6:0];
  f3    = instr[14:12];
  f7    = instr[31:25];
  rd    = instr[11:7];
  is_r  = (opc == OPC_R);
  is_i  = (opc == OPC_I);
  legal = is_r || is_i;
  if (is_r) begin
    legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
  end else if (is_i && f3 == 3'd1) begin
    legal = (f7 == 7'h00);
  end else if (is_i && f3 == 3'd5) begin
    legal = (f7 == 7'h00) || (f7 == 7'h20);
  end
  b   = is_r ? model_rf[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
  res = model_alu(f3, f7 == 7'h20, is_r, model_rf[instr[19:15]], b);
  if (legal && rd != 5'd0) model_rf[rd] = res;
  exp_cyc_q.push_back(cyc + 2);
  exp_ill_q.push_back(!legal);
  exp_rd_q.push_back(rd);
  exp_val_q.push_back(res);
  instr_valid_i = 1'b1;
  instr_i       = instr;
  @(posedge clk_int);
  #1 instr_valid_i = 1'b0;
endtask

task automatic drain();
  while (exp_cyc_q.size() != 0) @(posedge clk_int);
  #1;
endtask

// ADDI, SLLI, ORI sequence builds any 32-bit value
task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
  issue_instr(i_type({1'b0, v[31:21]}, 5'd0, 3'd0, rd));
  issue_instr(i_type(12'd11, rd, 3'd1, rd));
  issue_instr(i_type({1'b0, v[20:10]}, rd, 3'd6, rd));
  issue_instr(i_type(12'd10, rd, 3'd1, rd));
  issue_instr(i_type({2'b0, v[9:0]}, rd, 3'd6, rd));
endtask

task automatic test_reset();
  test_name = "reset";
  assert (result_valid_o === 1'b0 && illegal_o === 1'b0) else begin
    $display("Result outputs active right after reset");
    stop_run();
  end
  for (int n = 0; n < 32; n++) begin
    issue_instr(r_type(7'h00, 5'd0, 5'(n), 3'd0, 5'(n)));
  end
  drain();
endtask

task automatic test_itype();
  logic [2:0]  f3;
  logic [11:0] imm;
  logic [4:0]  rs1;
  test_name = "itype";
  // Index 8 is SRAI, the rest follow funct3
  for (int k = 0; k < 9; k++) begin
    f3 = (k < 8) ? 3'(k) : 3'd5;
    for (int it = 0; it < 3; it++) begin
      rs1 = rand_reg();
      load_reg(rs1, rand_bits(32));
      if (f3 == 3'd1 || f3 == 3'd5) begin
        imm = {(k == 8) ? 7'h20 : 7'h00, 5'(rand_bits(5))};
      end else begin
        imm = 12'(rand_bits(12));
      end
      issue_instr(i_type(imm, rs1, f3, rand_reg()));
    end
  end
  drain();
endtask

task automatic test_rtype();
  logic [6:0]  f7s [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                            7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
  logic [2:0]  f3s [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] a;
  logic [31:0] b;
  test_name = "rtype";
  for (int k = 0; k < 10; k++) begin
    for (int it = 0; it < 4; it++) begin
      rs1 = rand_reg();
      rs2 = (rs1 == 5'd31) ? 5'd1 : rs1 + 5'd1;
      a   = rand_bits(32);
      b   = rand_bits(32);
      // Sign and shift boundaries first
      if (it == 0) begin
        a = 32'h8000_0000;
        b = 32'd31;
      end else if (it == 1) begin
        a = 32'hffff_ffff;
        b = 32'd32;
      end
      load_reg(rs1, a);
      load_reg(rs2, b);
      issue_instr(r_type(f7s[k], rs2, rs1, f3s[k], rand_reg()));
    end
  end
  drain();
endtask

task automatic test_dependent();
  logic [4:0] rd;
  logic [4:0] p1;
  logic [4:0] p2;
  logic [2:0] f3;
  logic [6:0] f7;
  test_name = "dependent";
  load_reg(5'd2, rand_bits(32));
  load_reg(5'd3, rand_bits(32));
  p1 = 5'd3;
  p2 = 5'd2;
  // Strobe every cycle, sources are the last two destinations
  for (int i = 0; i < 20; i++) begin
    rd = 5'd4 + 5'(i % 4);
    f3 = 3'(rand_bits(3));
    f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) == 32'd1) ? 7'h20 : 7'h00;
    issue_instr(r_type(f7, p2, p1, f3, rd));
    p2 = p1;
    p1 = rd;
  end
  drain();
endtask

task automatic test_x0_write();
  test_name = "x0_write";
  load_reg(5'd6, rand_bits(32));
  issue_instr(i_type(12'h123, 5'd6, 3'd0, 5'd0));
  // Next cycle must not see the x0 result by bypass
  issue_instr(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd8));
  issue_instr(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd0));
  drain();
endtask

task automatic test_illegal();
  logic [31:0] words [6];
  logic [31:0] w;
  logic [4:0]  rd;
  test_name = "illegal";
  words[0] = {25'h0, 7'b0000011};
  words[1] = {25'h0, 7'b1111111};
  words[2] = {25'h0, 7'b0110111};
  words[3] = i_type({7'h20, 5'd3}, 5'd1, 3'd1, 5'd0);
  words[4] = i_type({7'h40, 5'd4}, 5'd1, 3'd5, 5'd0);
  words[5] = i_type({7'h60, 5'd2}, 5'd1, 3'd5, 5'd0);
  for (int k = 0; k < 6; k++) begin
    rd = rand_reg();
    load_reg(rd, rand_bits(32));
    w        = words[k];
    w[11:7]  = rd;
    w[31:12] = (k < 3) ? 20'(rand_bits(20)) : w[31:12];
    issue_instr(w);
    // Readback shows rd unchanged in the next two cycles
    // The second read sees the file after write-back
    issue_instr(r_type(7'h00, 5'd0, rd, 3'd0, 5'd0));
    issue_instr(r_type(7'h00, 5'd0, rd, 3'd0, 5'd0));
  end
  drain();
endtask

//--- tb/tb_exec_unit.sv
/*
 * Testbench for the execute subsystem
 * Reference register model, result monitor, LFSR stimulus and timeout
 */
`timescale 1ns/1ps

module tb_exec_unit;

  localparam int TIMEOUT_CYCLES = 3000;
  localparam logic [6:0] OPC_R = 7'b0110011;
  localparam logic [6:0] OPC_I = 7'b0010011;

  logic        clk_int;
  logic        rst_ni;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic        result_valid_o;
  logic [4:0]  result_rd_o;
  logic [31:0] result_o;
  logic        illegal_o;

  // Reference register file, entry 0 never written
  logic [31:0] model_rf [32];
  logic [31:0] lfsr_q;
  int          cyc;
  string       test_name;

  // Expected results, one entry per strobed instruction
  int          exp_cyc_q [$];
  bit          exp_ill_q [$];
  logic [4:0]  exp_rd_q  [$];
  logic [31:0] exp_val_q [$];

  exec_unit_top #(
    .RV32E (1'b0)
  ) DUT (
    .clk_int        (clk_int),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .result_valid_o (result_valid_o),
    .result_rd_o    (result_rd_o),
    .result_o       (result_o),
    .illegal_o      (illegal_o)
  );

  initial begin
    clk_int = 1'b0;
    forever #10 clk_int = ~clk_int;
  end

  task automatic stop_run();
    $display("Checks failed");
    $fatal(1, "Simulation stopped on first error");
  endtask

  // Cycle count and run limit
  always @(posedge clk_int) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_run();
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  // Reference ALU from funct3 and the alternate bit
  function automatic logic [31:0] model_alu(logic [2:0] f3, logic alt, logic is_r,
                                            logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0:    return (is_r && alt) ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Outputs sampled at the falling edge, away from the drive point
  always @(negedge clk_int) begin
    bit          e_ill;
    logic [4:0]  e_rd;
    logic [31:0] e_val;
    if (exp_cyc_q.size() != 0 && exp_cyc_q[0] == cyc) begin
      void'(exp_cyc_q.pop_front());
      e_ill = exp_ill_q.pop_front();
      e_rd  = exp_rd_q.pop_front();
      e_val = exp_val_q.pop_front();
      assert (illegal_o === e_ill && result_valid_o === !e_ill) else begin
        $display("mismatch in %s: expected illegal %0b valid %0b, actual illegal %0b valid %0b",
                 test_name, e_ill, !e_ill, illegal_o, result_valid_o);
        stop_run();
      end
      if (!e_ill) begin
        assert (result_rd_o === e_rd) else begin
          $display("mismatch in %s: expected rd %0d, actual %0d", test_name, e_rd, result_rd_o);
          stop_run();
        end
        assert (result_o === e_val) else begin
          $display("mismatch in %s: expected result %08h, actual %08h",
                   test_name, e_val, result_o);
          stop_run();
        end
      end
    end else begin
      assert (result_valid_o === 1'b0 && illegal_o === 1'b0) else begin
        $display("Unexpected output pulse in cycle %0d during %s", cyc, test_name);
        stop_run();
      end
    end
  end

  `include "exec_tests.svh"

  initial begin
    instr_valid_i = 1'b0;
    instr_i       = '0;
    rst_ni        = 1'b0;
    lfsr_q        = 32'hb752_be72;
    cyc           = 0;
    test_name     = "reset";
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    repeat (5) @(posedge clk_int);
    #1 rst_ni = 1'b1;
    test_reset();
    test_itype();
    test_rtype();
    test_dependent();
    test_x0_write();
    test_illegal();
    $display("All checks passed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+tb
rtl/riscv_isa_pkg.sv
rtl/exec_pkg.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/operand_select.sv
rtl/exec_controller.sv
rtl/exec_unit_top.sv
tb/tb_exec_unit.sv

//--- Makefile
# Verilator build and run for the execute subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_unit
FILELIST  ?= vlog.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
